// ==== alpha_cfg.svh ====
`ifndef ALPHA_CFG_SVH
`define ALPHA_CFG_SVH

// ----------------------------------------------------------
// widths
// ----------------------------------------------------------
`define ALPHA_DAC_VALUE_BITS 12 // bias dac value
`define ALPHA_DAC_ADDR_BITS 4 // address field, sent first on sin
`define ALPHA_NUM_DACS 4 // CMPbias, ISEL, SBbias, DBbias
`define ALPHA_COUNT_BITS 8 // all sequence counters

// ----------------------------------------------------------
// sequence lengths, in clock cycles
// ----------------------------------------------------------
`define ALPHA_DEBOUNCE_CYCLES 8 // button must stay high this long
`define ALPHA_DRESET_CYCLES 16 // dreset pattern length
`define ALPHA_TRIG_CYCLES 4 // trigger pulse width
`define ALPHA_PCLK_CYCLES 2 // latch pulse after each dac word

// ----------------------------------------------------------
// bias dac values
// ----------------------------------------------------------
// addresses follow the order below, CMPbias at 0 up to DBbias at 3
`define ALPHA_CMPBIAS 12'h1e8 // comparator bias
`define ALPHA_ISEL 12'ha80 // ramp current, sets ramp length
`define ALPHA_SBBIAS 12'hdff // sample buffer bias
`define ALPHA_DBBIAS 12'h7ff // driver buffer bias

`endif

// ==== alpha_pkg.sv ====
`default_nettype none

`include "alpha_cfg.svh"

package alpha_pkg;

	// ----------------------------------------------------------
	// vector types
	// ----------------------------------------------------------
	typedef logic [`ALPHA_DAC_VALUE_BITS-1:0] dac_value_t; // one bias setting
	typedef logic [`ALPHA_DAC_ADDR_BITS-1:0] dac_addr_t; // which dac
	// address in the upper bits so it leaves first, msb first
	typedef logic [`ALPHA_DAC_ADDR_BITS+`ALPHA_DAC_VALUE_BITS-1:0] serial_word_t;
	typedef logic [`ALPHA_COUNT_BITS-1:0] seq_count_t; // shared counter width

	// ----------------------------------------------------------
	// state machines
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		st_idle, // nothing to do
		st_wait_grant, // req up, pins not ours yet
		st_shift_low, // sin set up, sclk low
		st_shift_high, // sclk high, sin held
		st_latch, // pclk pulse
		st_next // gap before next word or release
	} loader_state_t;

	// who owns the chip pins
	typedef enum logic [1:0] {
		grant_none,
		grant_dreset,
		grant_trigger,
		grant_loader
	} grant_t;

endpackage

`default_nettype wire

// ==== alpha_pin_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one sequencer's view of the shared chip control pins
interface alpha_pin_if;
	logic req; // held for the whole sequence
	logic grant; // pins belong to this client
	logic sin; // serial data
	logic sclk; // serial clock
	logic pclk; // parallel latch
	logic dreset; // digital reset
	logic trig; // trigger pulse

	// sequencer side
	modport client (
		output req,
		output sin, sclk, pclk, dreset, trig,
		input grant
	);

	// arbiter side
	modport arbiter (
		input req,
		input sin, sclk, pclk, dreset, trig,
		output grant
	);
endinterface

`default_nettype wire

// ==== button_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alpha_cfg.svh"

// one press pulse per stable high level on a raw button
module button_debounce (
	input logic clock,
	input logic reset,
	input logic raw, // button level, active high
	output logic press // one cycle wide
);
	alpha_pkg::seq_count_t count; // consecutive high cycles
	logic armed; // cleared after a press, set again by a low level

	always_ff @(posedge clock) begin
		press <= 1'b0; // pulse by default
		if (reset) begin
			count <= '0;
			armed <= 1'b1;
		end else if (!raw) begin
			// released, start over and allow the next press
			count <= '0;
			armed <= 1'b1;
		end else if (armed) begin
			if (count == alpha_pkg::seq_count_t'(`ALPHA_DEBOUNCE_CYCLES - 1)) begin
				press <= 1'b1; // stable long enough
				armed <= 1'b0; // wait for release
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
		// held high after the pulse, nothing more until release
	end

endmodule

`default_nettype wire

// ==== dreset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alpha_cfg.svh"

// digital reset of the chip
// holds dreset, pclk and sclk high together for a fixed number of granted cycles
module dreset_sequencer (
	input logic clock,
	input logic reset,
	input logic start, // debounced button 3
	alpha_pin_if.client bus
);
	alpha_pkg::seq_count_t count; // granted cycles so far
	logic active; // we own the pins this cycle

	assign active = bus.req && bus.grant;

	// ----------------------------------------------------------
	// request and count
	// ----------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			bus.req <= 1'b0;
			count <= '0;
		end else if (!bus.req) begin
			if (start) begin
				bus.req <= 1'b1; // start while busy is dropped
			end
			count <= '0;
		end else if (active) begin
			if (count == alpha_pkg::seq_count_t'(`ALPHA_DRESET_CYCLES - 1)) begin
				bus.req <= 1'b0; // last pattern cycle, release
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
		// req high without grant, keep waiting
	end

	// reset pattern, low whenever the pins are not ours
	assign bus.dreset = active;
	assign bus.pclk = active;
	assign bus.sclk = active;
	assign bus.sin = 1'b0; // no data during reset
	assign bus.trig = 1'b0;

endmodule

`default_nettype wire

// ==== trigger_pulser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alpha_cfg.svh"

// single trigger pulse for the chip
// going through the arbiter keeps it out of a reset or a serial load
module trigger_pulser (
	input logic clock,
	input logic reset,
	input logic start, // debounced button 0
	alpha_pin_if.client bus
);
	alpha_pkg::seq_count_t count; // granted cycles so far
	logic active;

	assign active = bus.req && bus.grant;

	always_ff @(posedge clock) begin
		if (reset) begin
			bus.req <= 1'b0;
			count <= '0;
		end else if (!bus.req) begin
			if (start) begin
				bus.req <= 1'b1;
			end
			count <= '0;
		end else if (active) begin
			if (count == alpha_pkg::seq_count_t'(`ALPHA_TRIG_CYCLES - 1)) begin
				bus.req <= 1'b0; // pulse done
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// only trig moves, rest of the pins stay quiet
	assign bus.trig = active;
	assign bus.dreset = 1'b0;
	assign bus.pclk = 1'b0;
	assign bus.sclk = 1'b0;
	assign bus.sin = 1'b0;

endmodule

`default_nettype wire

// ==== dac_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alpha_cfg.svh"

// legacy serial load of the four bias dacs
// each word is address then value, msb first on sin
// two cycles per bit, then a pclk latch with sclk low
module dac_loader (
	input logic clock,
	input logic reset,
	input logic start, // debounced button 2
	alpha_pin_if.client bus
);
	localparam int word_bits = $bits(alpha_pkg::serial_word_t);
	localparam int bit_index_bits = $clog2(word_bits);

	alpha_pkg::loader_state_t state;
	alpha_pkg::dac_addr_t dac_index; // doubles as the dac address
	logic [bit_index_bits-1:0] bit_index; // bit now on sin
	alpha_pkg::seq_count_t pclk_count; // cycles of pclk so far
	alpha_pkg::dac_value_t dac_value;
	alpha_pkg::serial_word_t word; // word being shifted
	logic active;
	logic shifting;

	// ----------------------------------------------------------
	// word build
	// ----------------------------------------------------------
	always_comb begin
		case (dac_index)
			alpha_pkg::dac_addr_t'(0): dac_value = `ALPHA_CMPBIAS;
			alpha_pkg::dac_addr_t'(1): dac_value = `ALPHA_ISEL;
			alpha_pkg::dac_addr_t'(2): dac_value = `ALPHA_SBBIAS;
			alpha_pkg::dac_addr_t'(3): dac_value = `ALPHA_DBBIAS;
			default: dac_value = '0; // past the last dac
		endcase
	end

	assign word = {dac_index, dac_value};

	// ----------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= alpha_pkg::st_idle;
			bus.req <= 1'b0;
			dac_index <= '0;
			bit_index <= '0;
			pclk_count <= '0;
		end else begin
			case (state)
				alpha_pkg::st_idle: begin
					if (start) begin
						bus.req <= 1'b1;
						state <= alpha_pkg::st_wait_grant;
					end
				end
				alpha_pkg::st_wait_grant: begin
					if (bus.grant) begin
						dac_index <= '0; // CMPbias first
						bit_index <= bit_index_bits'(word_bits - 1);
						state <= alpha_pkg::st_shift_low;
					end
				end
				alpha_pkg::st_shift_low: state <= alpha_pkg::st_shift_high; // sin settles
				alpha_pkg::st_shift_high: begin
					if (bit_index == '0) begin
						pclk_count <= '0;
						state <= alpha_pkg::st_latch; // word complete
					end else begin
						bit_index <= bit_index - 1'b1;
						state <= alpha_pkg::st_shift_low;
					end
				end
				alpha_pkg::st_latch: begin
					if (pclk_count == alpha_pkg::seq_count_t'(`ALPHA_PCLK_CYCLES - 1)) begin
						state <= alpha_pkg::st_next;
					end else begin
						pclk_count <= pclk_count + 1'b1;
					end
				end
				alpha_pkg::st_next: begin
					if (dac_index == alpha_pkg::dac_addr_t'(`ALPHA_NUM_DACS - 1)) begin
						bus.req <= 1'b0; // fourth latch done, give pins back
						state <= alpha_pkg::st_idle;
					end else begin
						dac_index <= dac_index + 1'b1;
						bit_index <= bit_index_bits'(word_bits - 1);
						state <= alpha_pkg::st_shift_low;
					end
				end
				default: state <= alpha_pkg::st_idle;
			endcase
		end
	end

	// ----------------------------------------------------------
	// pins
	// ----------------------------------------------------------
	assign active = bus.req && bus.grant;
	assign shifting = (state == alpha_pkg::st_shift_low) || (state == alpha_pkg::st_shift_high);
	assign bus.sin = active && shifting && word[bit_index]; // same bit for both halves
	assign bus.sclk = active && (state == alpha_pkg::st_shift_high);
	assign bus.pclk = active && (state == alpha_pkg::st_latch); // sclk low here
	assign bus.dreset = 1'b0;
	assign bus.trig = 1'b0;

endmodule

`default_nettype wire

// ==== pin_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// shares the chip control pins between the three sequencers
// fixed priority dreset, trigger, loader, and no preemption
module pin_arbiter (
	input logic clock,
	input logic reset,
	input logic bottom_enable, // lets trig reach the bottom chip
	alpha_pin_if.arbiter dreset_bus,
	alpha_pin_if.arbiter trigger_bus,
	alpha_pin_if.arbiter loader_bus,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic dreset,
	output logic auxtrig,
	output logic trig_top,
	output logic trig_bot
);
	alpha_pkg::grant_t owner; // current pin owner
	logic sel_sin, sel_sclk, sel_pclk, sel_dreset, sel_trig; // owner's pins

	// ----------------------------------------------------------
	// grant
	// ----------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= alpha_pkg::grant_none;
		end else begin
			case (owner)
				alpha_pkg::grant_none: begin
					// only pick a new owner once the pins are free
					if (dreset_bus.req) owner <= alpha_pkg::grant_dreset;
					else if (trigger_bus.req) owner <= alpha_pkg::grant_trigger;
					else if (loader_bus.req) owner <= alpha_pkg::grant_loader;
				end
				alpha_pkg::grant_dreset: if (!dreset_bus.req) owner <= alpha_pkg::grant_none;
				alpha_pkg::grant_trigger: if (!trigger_bus.req) owner <= alpha_pkg::grant_none;
				alpha_pkg::grant_loader: if (!loader_bus.req) owner <= alpha_pkg::grant_none;
				default: owner <= alpha_pkg::grant_none;
			endcase
		end
	end

	assign dreset_bus.grant = (owner == alpha_pkg::grant_dreset);
	assign trigger_bus.grant = (owner == alpha_pkg::grant_trigger);
	assign loader_bus.grant = (owner == alpha_pkg::grant_loader);

	// ----------------------------------------------------------
	// pin mux and output registers
	// ----------------------------------------------------------
	always_comb begin
		{sel_sin, sel_sclk, sel_pclk, sel_dreset, sel_trig} = '0; // nobody owns them
		case (owner)
			alpha_pkg::grant_dreset: {sel_sin, sel_sclk, sel_pclk, sel_dreset, sel_trig} =
				{dreset_bus.sin, dreset_bus.sclk, dreset_bus.pclk, dreset_bus.dreset, dreset_bus.trig};
			alpha_pkg::grant_trigger: {sel_sin, sel_sclk, sel_pclk, sel_dreset, sel_trig} =
				{trigger_bus.sin, trigger_bus.sclk, trigger_bus.pclk, trigger_bus.dreset, trigger_bus.trig};
			alpha_pkg::grant_loader: {sel_sin, sel_sclk, sel_pclk, sel_dreset, sel_trig} =
				{loader_bus.sin, loader_bus.sclk, loader_bus.pclk, loader_bus.dreset, loader_bus.trig};
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			{sin, sclk, pclk, dreset, auxtrig, trig_top, trig_bot} <= '0;
		end else begin
			sin <= sel_sin;
			sclk <= sel_sclk;
			pclk <= sel_pclk;
			dreset <= sel_dreset;
			auxtrig <= sel_dreset; // chip wants auxtrig high through dreset
			trig_top <= sel_trig;
			trig_bot <= sel_trig && bottom_enable; // bottom chip optional
		end
	end

endmodule

`default_nettype wire

// ==== alpha_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

// bench controller for one ALPHA chip
// buttons start a digital reset, a trigger or a bias dac load
module alpha_tester (
	input logic clock,
	input logic reset,
	input logic [3:0] buttons, // 3 dreset, 2 dac load, 1 unused, 0 trigger
	input logic bottom_enable, // copy trig onto trig_bot
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic dreset,
	output logic auxtrig,
	output logic trig_top,
	output logic trig_bot
);
	logic start_dreset; // button 3
	logic start_load; // button 2
	logic start_trigger; // button 0

	// ----------------------------------------------------------
	// buttons
	// ----------------------------------------------------------
	button_debounce button_3_debounce (
		.clock(clock), .reset(reset), .raw(buttons[3]), .press(start_dreset)
	);
	button_debounce button_2_debounce (
		.clock(clock), .reset(reset), .raw(buttons[2]), .press(start_load)
	);
	// button 1 was the i2c transfer, not wired here
	button_debounce button_0_debounce (
		.clock(clock), .reset(reset), .raw(buttons[0]), .press(start_trigger)
	);

	// ----------------------------------------------------------
	// sequencers
	// ----------------------------------------------------------
	alpha_pin_if dreset_bus ();
	alpha_pin_if trigger_bus ();
	alpha_pin_if loader_bus ();

	dreset_sequencer dreset_sequencer_inst (
		.clock(clock), .reset(reset), .start(start_dreset), .bus(dreset_bus.client)
	);
	trigger_pulser trigger_pulser_inst (
		.clock(clock), .reset(reset), .start(start_trigger), .bus(trigger_bus.client)
	);
	dac_loader dac_loader_inst (
		.clock(clock), .reset(reset), .start(start_load), .bus(loader_bus.client)
	);

	// ----------------------------------------------------------
	// pins
	// ----------------------------------------------------------
	pin_arbiter pin_arbiter_inst (
		.clock(clock),
		.reset(reset),
		.bottom_enable(bottom_enable),
		.dreset_bus(dreset_bus.arbiter), // highest priority
		.trigger_bus(trigger_bus.arbiter),
		.loader_bus(loader_bus.arbiter), // lowest
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk),
		.dreset(dreset),
		.auxtrig(auxtrig),
		.trig_top(trig_top),
		.trig_bot(trig_bot)
	);

endmodule

`default_nettype wire

// ==== alpha_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol rules on the registered chip pins
module alpha_checker (
	input logic clock,
	input logic reset,
	input logic sin,
	input logic sclk,
	input logic pclk,
	input logic dreset,
	input logic auxtrig,
	input logic trig_top,
	input logic trig_bot
);
	int failures = 0; // assertion failures so far

	// ----------------------------------------------------------
	// pin rules
	// ----------------------------------------------------------
	trig_outside_dreset: assert property (@(posedge clock) disable iff (reset)
		!(trig_top && dreset)) // trigger never lands in a reset
		else begin
			$error("trig_top high during dreset");
			failures++;
		end

	// data held across the sclk high phase
	sin_stable: assert property (@(posedge clock) disable iff (reset)
		(sclk && !dreset) |-> (sin == $past(sin)))
		else begin
			$error("sin moved while sclk high");
			failures++;
		end

	latch_apart: assert property (@(posedge clock) disable iff (reset)
		!dreset |-> !(pclk && sclk)) // only the reset pattern has both
		else begin
			$error("pclk and sclk high together outside dreset");
			failures++;
		end

	quiet_after_reset: assert property (@(posedge clock)
		$past(reset) |-> ({sin, sclk, pclk, dreset, auxtrig, trig_top, trig_bot} == '0))
		else begin
			$error("pins not low after reset");
			failures++;
		end

endmodule

bind pin_arbiter alpha_checker alpha_checker_inst (
	.clock(clock), .reset(reset), .sin(sin), .sclk(sclk), .pclk(pclk), .dreset(dreset),
	.auxtrig(auxtrig), .trig_top(trig_top), .trig_bot(trig_bot)
);

`default_nettype wire

// ==== tb_alpha_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alpha_cfg.svh"

module tb_alpha_tester;
	localparam int word_bits = `ALPHA_DAC_ADDR_BITS + `ALPHA_DAC_VALUE_BITS;
	localparam int num_rows = 7;
	localparam int settle_cycles = 24; // idle window that ends a row
	localparam byte ev_reset = 8'h52;
	localparam byte ev_trig = 8'h54;
	localparam byte ev_word = 8'h44;

	typedef struct {
		logic [3:0] mask; // buttons held together
		logic be; // bottom_enable for the row
		int hold; // cycles the buttons stay high
		int resets; // expected dreset runs
		int tops; // expected trig_top runs
		int bots; // expected trig_bot runs
		int words; // expected decoded dac words
	} row_t;

	logic clock = 1'b0;
	logic reset;
	logic [3:0] buttons;
	logic bottom_enable;
	logic sin, sclk, pclk, dreset, auxtrig, trig_top, trig_bot;

	row_t rows [num_rows];
	int reset_total = 0, top_total = 0, bot_total = 0, word_total = 0;
	int dreset_run = 0, trig_run = 0, bit_count = 0;
	int cycle_count = 0, timeout_limit = 0;
	logic sclk_q = 1'b0, pclk_q = 1'b0, trig_bot_q = 1'b0;
	logic [word_bits-1:0] shift_word = '0; // rebuilt from sin
	byte event_log [$]; // completed sequences in order

	alpha_tester alpha_tester_inst (
		.clock(clock), .reset(reset), .buttons(buttons), .bottom_enable(bottom_enable),
		.sin(sin), .sclk(sclk), .pclk(pclk), .dreset(dreset), .auxtrig(auxtrig),
		.trig_top(trig_top), .trig_bot(trig_bot)
	);

	always #10 clock = ~clock; // 20 ns period

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// address in the top bits, value below, dacs in configured order
	function automatic logic [word_bits-1:0] expected_dac_word(input int index);
		logic [`ALPHA_DAC_VALUE_BITS-1:0] value;
		case (index)
			0: value = `ALPHA_CMPBIAS;
			1: value = `ALPHA_ISEL;
			2: value = `ALPHA_SBBIAS;
			default: value = `ALPHA_DBBIAS;
		endcase
		return {index[`ALPHA_DAC_ADDR_BITS-1:0], value};
	endfunction

	// ----------------------------------------------------------
	// pin monitors
	// ----------------------------------------------------------
	always @(posedge clock) begin
		check_value("checker assertions", 0,
			alpha_tester_inst.pin_arbiter_inst.alpha_checker_inst.failures);
		if (dreset) begin
			dreset_run++;
			check_value("pclk in dreset", 1, pclk);
			check_value("sclk in dreset", 1, sclk);
			check_value("auxtrig in dreset", 1, auxtrig);
		end else if (dreset_run != 0) begin
			check_value("dreset run length", `ALPHA_DRESET_CYCLES, dreset_run);
			reset_total++;
			event_log.push_back(ev_reset);
			dreset_run = 0;
		end
		if (trig_top) begin
			trig_run++;
			check_value("serial pins in trig", 0, {sin, sclk, pclk}); // no overlap
		end else if (trig_run != 0) begin
			check_value("trig_top run length", `ALPHA_TRIG_CYCLES, trig_run);
			top_total++;
			event_log.push_back(ev_trig);
			trig_run = 0;
		end
		check_value("trig_bot", trig_top && bottom_enable, trig_bot);
		if (trig_bot && !trig_bot_q) bot_total++;
		if (!dreset && sclk && !sclk_q) begin // bit sampled at sclk rise
			shift_word = {shift_word[word_bits-2:0], sin};
			bit_count++;
		end
		if (!dreset && pclk && !pclk_q) begin // latch closes the word
			check_value("bits per word", word_bits, bit_count);
			check_value("dac word", expected_dac_word(word_total % `ALPHA_NUM_DACS), shift_word);
			word_total++;
			event_log.push_back(ev_word);
			bit_count = 0;
		end
		sclk_q = sclk;
		pclk_q = pclk;
		trig_bot_q = trig_bot;
	end

	// run limit
	always @(posedge clock) begin
		cycle_count++;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			$display("timeout: sequences never finished");
			$display("Test FAILED");
			$fatal(1, "run stopped after %0d cycles", cycle_count);
		end
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		int base_r, base_t, base_b, base_w, base_e, quiet, gap, n, limit;
		byte code;
		reset = 1'b1;
		buttons = '0;
		bottom_enable = 1'b0;
		void'($urandom(21));
		rows[0] = '{4'b1000, 1'b0, `ALPHA_DEBOUNCE_CYCLES - 1, 0, 0, 0, 0}; // too short
		rows[1] = '{4'b1000, 1'b0, 12, 1, 0, 0, 0};
		rows[2] = '{4'b0001, 1'b1, 30, 0, 1, 1, 0}; // held past the end of the pulse
		rows[3] = '{4'b0001, 1'b0, `ALPHA_DEBOUNCE_CYCLES, 0, 1, 0, 0}; // just long enough
		rows[4] = '{4'b0100, 1'b0, 30, 0, 0, 0, 4};
		rows[5] = '{4'b0010, 1'b1, 12, 0, 0, 0, 0}; // button 1 not wired
		rows[6] = '{4'b1101, 1'b1, 10, 1, 1, 1, 4}; // all three at once
		limit = 100;
		for (int r = 0; r < num_rows; r++) begin
			limit += rows[r].hold + settle_cycles + 24 + rows[r].resets * (`ALPHA_DRESET_CYCLES + 4)
				+ rows[r].tops * (`ALPHA_TRIG_CYCLES + 4)
				+ rows[r].words * (2 * word_bits + `ALPHA_PCLK_CYCLES + 4);
		end
		timeout_limit = 2 * limit; // margin
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		repeat (8) begin // nothing moves before a press
			@(posedge clock);
			check_value("pins after reset", 0, {sin, sclk, pclk, dreset, auxtrig, trig_top, trig_bot});
		end
		for (int r = 0; r < num_rows; r++) begin
			base_r = reset_total;
			base_t = top_total;
			base_b = bot_total;
			base_w = word_total;
			base_e = event_log.size();
			bottom_enable <= rows[r].be;
			@(posedge clock);
			buttons <= rows[r].mask;
			repeat (rows[r].hold) @(posedge clock);
			buttons <= '0;
			while (reset_total - base_r < rows[r].resets || top_total - base_t < rows[r].tops
					|| bot_total - base_b < rows[r].bots || word_total - base_w < rows[r].words)
				@(posedge clock);
			quiet = 0;
			while (quiet < settle_cycles) begin // all pins idle for a while
				@(posedge clock);
				if ({sin, sclk, pclk, dreset, trig_top, trig_bot} == '0) quiet++;
				else quiet = 0;
			end
			check_value("dreset runs", rows[r].resets, reset_total - base_r);
			check_value("trig_top runs", rows[r].tops, top_total - base_t);
			check_value("trig_bot runs", rows[r].bots, bot_total - base_b);
			check_value("dac words", rows[r].words, word_total - base_w);
			// priority order, dreset then trigger then load
			n = event_log.size() - base_e;
			check_value("sequence count", rows[r].resets + rows[r].tops + rows[r].words, n);
			for (int i = 0; i < n; i++) begin
				if (i < rows[r].resets) code = ev_reset;
				else if (i < rows[r].resets + rows[r].tops) code = ev_trig;
				else code = ev_word;
				check_value("sequence order", code, event_log[base_e + i]);
			end
			gap = 4 + ($urandom % 16); // idle gap between rows
			repeat (gap) @(posedge clock);
		end
		if (alpha_tester_inst.pin_arbiter_inst.alpha_checker_inst.failures == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Test FAILED");
			$fatal(1, "assertion failures in the pin checker");
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
alpha_pkg.sv
alpha_pin_if.sv
button_debounce.sv
dreset_sequencer.sv
trigger_pulser.sv
dac_loader.sv
pin_arbiter.sv
alpha_tester.sv
alpha_checker.sv
tb_alpha_tester.sv

// ==== Bender.yml ====
package:
  name: alpha_tester

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - alpha_pkg.sv
      - alpha_pin_if.sv
      - button_debounce.sv
      - dreset_sequencer.sv
      - trigger_pulser.sv
      - dac_loader.sv
      - pin_arbiter.sv
      - alpha_tester.sv
  - target: test
    include_dirs:
      - .
    files:
      - alpha_checker.sv
      - tb_alpha_tester.sv
